// File: Makefile
VERILATOR ?= verilator
TOP       ?= rvExecUnitTb
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LOG       ?= sim.log
PASS_TEXT ?= All checks passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: design/aluDecode.sv
`timescale 1ns/1ps
`default_nettype none

module aluDecode (
    input  rvExecPkg::aluOpT   aluOp,    // Class from the opcode
    input  logic [2:0]         funct3,   // Bits 14:12
    input  logic               funct75,  // Bit 30
    output rvExecPkg::aluCtrlT aluCtrl   // ALU control code
);

    always_comb begin
        case (aluOp)
            rvExecPkg::opR: begin
                case ({funct3, funct75})
                    4'b0000: aluCtrl = rvExecPkg::aluAdd;
                    4'b0001: aluCtrl = rvExecPkg::aluSub;
                    4'b1000: aluCtrl = rvExecPkg::aluXor;
                    4'b1100: aluCtrl = rvExecPkg::aluOr;
                    4'b1110: aluCtrl = rvExecPkg::aluAnd;
                    4'b0010: aluCtrl = rvExecPkg::aluSll;
                    4'b1010: aluCtrl = rvExecPkg::aluSrl;
                    4'b1011: aluCtrl = rvExecPkg::aluSra;
                    4'b0100: aluCtrl = rvExecPkg::aluSlt;
                    4'b0110: aluCtrl = rvExecPkg::aluSltu;
                    default: aluCtrl = rvExecPkg::aluAdd;  // Unlisted funct7 falls back to add
                endcase
            end

            rvExecPkg::opI: begin
                case (funct3)
                    3'b000:  aluCtrl = rvExecPkg::aluAdd;   // Addi
                    3'b100:  aluCtrl = rvExecPkg::aluXor;   // Xori
                    3'b110:  aluCtrl = rvExecPkg::aluOr;    // Ori
                    3'b111:  aluCtrl = rvExecPkg::aluAnd;   // Andi
                    3'b001:  aluCtrl = rvExecPkg::aluSll;   // Slli
                    3'b101: begin
                        if (funct75) begin
                            aluCtrl = rvExecPkg::aluSra;    // Srai
                        end else begin
                            aluCtrl = rvExecPkg::aluSrl;    // Srli
                        end
                    end
                    3'b010:  aluCtrl = rvExecPkg::aluSlt;   // Slti
                    3'b011:  aluCtrl = rvExecPkg::aluSltu;  // Sltiu
                    default: aluCtrl = rvExecPkg::aluAdd;
                endcase
            end

            rvExecPkg::opBranch: begin
                case (funct3)
                    3'b000:  aluCtrl = rvExecPkg::aluBeq;
                    3'b001:  aluCtrl = rvExecPkg::aluBne;
                    3'b100:  aluCtrl = rvExecPkg::aluBlt;
                    3'b101:  aluCtrl = rvExecPkg::aluBge;
                    3'b110:  aluCtrl = rvExecPkg::aluBltu;  // Unsigned less than
                    3'b111:  aluCtrl = rvExecPkg::aluBgeu;
                    default: aluCtrl = rvExecPkg::aluAdd;   // Reserved funct3
                endcase
            end

            rvExecPkg::opLui: aluCtrl = rvExecPkg::aluPassB;

            default: aluCtrl = rvExecPkg::aluAdd;  // Unsupported class
        endcase
    end

endmodule

`default_nettype wire

// File: design/execAlu.sv
`timescale 1ns/1ps
`default_nettype none

module execAlu (
    input  logic               clk,
    input  logic               rstN,
    input  logic               capture,    // Execute cycle
    input  logic               shiftStep,  // Shift one position
    input  rvExecPkg::aluCtrlT aluCtrl,
    input  rvExecPkg::wordT    srcA,
    input  rvExecPkg::wordT    srcB,
    output rvExecPkg::wordT    result,     // Also the shift register
    output logic               taken,      // Branch condition
    output rvExecPkg::shamtT   shamt       // Loads the timer
);

    rvExecPkg::wordT opA;       // Operands held from the read cycle
    rvExecPkg::wordT opB;
    rvExecPkg::wordT aluNext;
    rvExecPkg::wordT shiftSrc;
    rvExecPkg::wordT shiftNext;
    logic            isShift;
    logic            branchHit;

    assign shamt   = srcB[4:0];
    assign isShift = aluCtrl inside {rvExecPkg::aluSll, rvExecPkg::aluSrl, rvExecPkg::aluSra};

    always_ff @(posedge clk) begin
        opA <= srcA;
        opB <= srcB;
    end

    always_comb begin
        case (aluCtrl)
            rvExecPkg::aluAdd:   aluNext = opA + opB;
            rvExecPkg::aluSub:   aluNext = opA - opB;
            rvExecPkg::aluXor:   aluNext = opA ^ opB;
            rvExecPkg::aluOr:    aluNext = opA | opB;
            rvExecPkg::aluAnd:   aluNext = opA & opB;
            rvExecPkg::aluSlt:   aluNext = {31'b0, $signed(opA) < $signed(opB)};
            rvExecPkg::aluSltu:  aluNext = {31'b0, opA < opB};
            rvExecPkg::aluPassB: aluNext = opB;  // Lui
            default:             aluNext = '0;   // Branches write nothing
        endcase
    end

    always_comb begin
        case (aluCtrl)
            rvExecPkg::aluBeq:  branchHit = (opA == opB);
            rvExecPkg::aluBne:  branchHit = (opA != opB);
            rvExecPkg::aluBlt:  branchHit = ($signed(opA) < $signed(opB));
            rvExecPkg::aluBge:  branchHit = ($signed(opA) >= $signed(opB));
            rvExecPkg::aluBltu: branchHit = (opA < opB);
            rvExecPkg::aluBgeu: branchHit = (opA >= opB);
            default:            branchHit = 1'b0;
        endcase
    end

    // First step can land in the capture cycle itself
    always_comb begin
        shiftSrc = capture ? opA : result;
        case (aluCtrl)
            rvExecPkg::aluSll: shiftNext = {shiftSrc[30:0], 1'b0};
            rvExecPkg::aluSrl: shiftNext = {1'b0, shiftSrc[31:1]};
            rvExecPkg::aluSra: shiftNext = {shiftSrc[31], shiftSrc[31:1]};  // Sign fill
            default:           shiftNext = shiftSrc;
        endcase
    end

    always_ff @(posedge clk) begin
        if (isShift && shiftStep) begin
            result <= shiftNext;
        end else if (capture) begin
            result <= isShift ? opA : aluNext;  // Zero-length shift keeps opA
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            taken <= 1'b0;
        end else if (capture) begin
            taken <= branchHit;
        end
    end

endmodule

`default_nettype wire

// File: design/execControl.sv
`timescale 1ns/1ps
`default_nettype none

module execControl (
    input  logic                    clk,
    input  logic                    rstN,
    input  logic                    instrValid,  // Accept strobe
    input  rvExecPkg::wordT         instr,
    input  rvExecPkg::decodedInstrT dec,
    input  rvExecPkg::aluCtrlT      aluCtrl,
    input  logic                    shiftZero,   // Timer drained
    output rvExecPkg::wordT         instrReg,    // Instruction in flight
    output logic                    capture,
    output logic                    shiftLoad,
    output logic                    regWe,
    output logic                    busy,
    output logic                    done,
    output logic                    illegal
);

    rvExecPkg::ctrlStateT state;
    rvExecPkg::ctrlStateT stateNext;
    logic                 isShift;

    assign isShift = aluCtrl inside {rvExecPkg::aluSll, rvExecPkg::aluSrl, rvExecPkg::aluSra};

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state    <= rvExecPkg::sIdle;
            instrReg <= '0;  // Opcode 0 decodes as unsupported
        end else begin
            state <= stateNext;
            if (state == rvExecPkg::sIdle && instrValid) begin
                instrReg <= instr;  // Accept edge
            end
        end
    end

    always_comb begin
        stateNext = state;
        case (state)
            rvExecPkg::sIdle:  if (instrValid) stateNext = rvExecPkg::sRead;
            rvExecPkg::sRead:  stateNext = dec.legal ? rvExecPkg::sExec : rvExecPkg::sWrite;
            rvExecPkg::sExec:  stateNext = (isShift && !shiftZero) ? rvExecPkg::sShift
                                                                   : rvExecPkg::sWrite;
            rvExecPkg::sShift: if (shiftZero) stateNext = rvExecPkg::sWrite;
            rvExecPkg::sWrite: stateNext = rvExecPkg::sIdle;  // Done pulse
            default:           stateNext = rvExecPkg::sIdle;
        endcase
    end

    assign shiftLoad = (state == rvExecPkg::sRead) && dec.legal && isShift;  // Count ready in sExec
    assign capture   = (state == rvExecPkg::sExec);
    assign busy      = (state != rvExecPkg::sIdle);
    assign done      = (state == rvExecPkg::sWrite);
    assign illegal   = done && !dec.legal;
    assign regWe     = done && dec.legal && dec.regWrite && (dec.rd != '0);  // x0 discarded

    assert property (@(posedge clk) disable iff (!rstN) done |=> !done)
        else $error("done held longer than one cycle");

endmodule

`default_nettype wire

// File: design/mainDecode.sv
`timescale 1ns/1ps
`default_nettype none

module mainDecode (
    input  rvExecPkg::wordT         instr,  // Registered instruction word
    output rvExecPkg::decodedInstrT dec     // Decoded fields
);

    localparam logic [6:0] opcodeR   = 7'b0110011;
    localparam logic [6:0] opcodeI   = 7'b0010011;
    localparam logic [6:0] opcodeB   = 7'b1100011;
    localparam logic [6:0] opcodeLui = 7'b0110111;

    logic [6:0]      opcode;
    rvExecPkg::wordT iImm;
    rvExecPkg::wordT bImm;
    rvExecPkg::wordT uImm;

    assign opcode = instr[6:0];
    assign iImm   = {{20{instr[31]}}, instr[31:20]};
    // Branch offset, not used by the compare itself
    assign bImm   = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign uImm   = {instr[31:12], 12'b0};

    always_comb begin
        dec          = '0;
        dec.funct3   = instr[14:12];
        dec.funct75  = instr[30];
        dec.rd       = instr[11:7];
        dec.rs1      = instr[19:15];
        dec.rs2      = instr[24:20];
        case (opcode)
            opcodeR: begin
                dec.aluOp    = rvExecPkg::opR;
                dec.regWrite = 1'b1;
                dec.legal    = 1'b1;
            end
            opcodeI: begin
                dec.aluOp    = rvExecPkg::opI;
                dec.imm      = iImm;
                dec.useImm   = 1'b1;
                dec.regWrite = 1'b1;
                dec.legal    = 1'b1;
                // Bit 30 only selects srai, elsewhere it is immediate data
                dec.funct75  = (instr[14:12] == 3'b101) ? instr[30] : 1'b0;
            end
            opcodeB: begin
                dec.aluOp    = rvExecPkg::opBranch;
                dec.imm      = bImm;
                dec.isBranch = 1'b1;  // Compares rs1 with rs2
                dec.legal    = 1'b1;
            end
            opcodeLui: begin
                dec.aluOp    = rvExecPkg::opLui;
                dec.imm      = uImm;
                dec.useImm   = 1'b1;
                dec.regWrite = 1'b1;
                dec.funct75  = 1'b0;
                dec.legal    = 1'b1;
            end
            default: begin
                dec.aluOp    = rvExecPkg::aluOpT'(3'b111);  // Unsupported class
            end
        endcase
    end

    // A branch never retires a register write
    always_comb begin
        if (!$isunknown(instr)) begin
            assert (!(dec.regWrite && dec.isBranch))
                else $error("Decoder flagged both regWrite and isBranch");
        end
    end

endmodule

`default_nettype wire

// File: design/regFile.sv
`timescale 1ns/1ps
`default_nettype none

module regFile #(
    parameter int regCount = 32  // 16 gives an RV32E-sized file
) (
    input  logic               clk,
    input  logic               rstN,
    input  rvExecPkg::regAddrT rs1,
    input  rvExecPkg::regAddrT rs2,
    input  rvExecPkg::regAddrT rd,
    input  logic               wrEn,
    input  rvExecPkg::wordT    wrData,
    output rvExecPkg::wordT    rs1Data,
    output rvExecPkg::wordT    rs2Data
);

    localparam int addrW = $clog2(regCount);  // Upper index bits ignored

    rvExecPkg::wordT  regs [regCount];
    logic [addrW-1:0] wrIdx;

    assign wrIdx   = rd[addrW-1:0];
    assign rs1Data = regs[rs1[addrW-1:0]];  // Entry 0 is never written
    assign rs2Data = regs[rs2[addrW-1:0]];

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < regCount; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn && (wrIdx != '0)) begin
            regs[wrIdx] <= wrData;  // Aliases of x0 dropped too
        end
    end

    assert property (@(posedge clk) disable iff (!rstN) regs[0] == '0)
        else $error("Register 0 holds a nonzero value");

endmodule

`default_nettype wire

// File: design/rvExecPkg.sv
`default_nettype none

package rvExecPkg;

    typedef logic [31:0] wordT;    // Data or instruction word
    typedef logic [4:0] regAddrT;  // Register index
    typedef logic [4:0] shamtT;    // Shift amount

    // Operation class from the opcode, other values are unsupported
    typedef enum logic [2:0] {
        opR      = 3'b000,  // Register-register
        opI      = 3'b001,  // Register-immediate
        opBranch = 3'b100,  // Conditional branch
        opLui    = 3'b110   // Load upper immediate
    } aluOpT;

    // ALU control codes, xor sits at 2 and and at 4
    typedef enum logic [4:0] {
        aluAdd   = 5'd0,
        aluSub   = 5'd1,
        aluXor   = 5'd2,
        aluOr    = 5'd3,
        aluAnd   = 5'd4,
        aluSll   = 5'd5,
        aluSrl   = 5'd6,
        aluSra   = 5'd7,
        aluSlt   = 5'd8,
        aluSltu  = 5'd9,
        aluBeq   = 5'd10,
        aluBne   = 5'd11,
        aluBlt   = 5'd12,
        aluBge   = 5'd13,
        aluBltu  = 5'd14,
        aluBgeu  = 5'd15,
        aluPassB = 5'd16   // Lui result is operand B
    } aluCtrlT;

    typedef enum logic [2:0] {sIdle, sRead, sExec, sShift, sWrite} ctrlStateT;

    typedef struct packed {
        aluOpT       aluOp;     // Operation class
        logic [2:0]  funct3;    // Bits 14:12
        logic        funct75;   // Bit 30, cleared where meaningless
        regAddrT     rd;
        regAddrT     rs1;
        regAddrT     rs2;
        wordT        imm;       // Sign-extended I, B or U immediate
        logic        useImm;    // Operand B is the immediate
        logic        regWrite;  // Result goes to rd
        logic        isBranch;
        logic        legal;     // Opcode supported
    } decodedInstrT;

endpackage

`default_nettype wire

// File: design/rvExecUnit.sv
`timescale 1ns/1ps
`default_nettype none

module rvExecUnit #(
    parameter int regCount = 32
) (
    input  logic               clk,
    input  logic               rstN,
    input  logic               instrValid,   // Ignored while busy
    input  rvExecPkg::wordT    instr,
    output logic               busy,
    output logic               done,         // Result fields valid
    output rvExecPkg::regAddrT rdAddr,
    output rvExecPkg::wordT    result,
    output logic               wrEn,
    output logic               branchTaken,
    output logic               illegal
);

    rvExecPkg::wordT         instrReg;
    rvExecPkg::decodedInstrT dec;
    rvExecPkg::aluCtrlT      aluCtrl;
    rvExecPkg::wordT         rs1Data;
    rvExecPkg::wordT         rs2Data;
    rvExecPkg::wordT         srcB;
    rvExecPkg::shamtT        shamt;
    logic                    capture;
    logic                    shiftLoad;
    logic                    shiftStep;
    logic                    shiftZero;
    logic                    regWe;
    logic                    taken;

    assign srcB        = dec.useImm ? dec.imm : rs2Data;  // Operand B select
    assign rdAddr      = dec.rd;
    assign wrEn        = regWe;
    assign branchTaken = taken && dec.isBranch;  // Stale compare masked

    execControl execControl_inst (
        .clk, .rstN, .instrValid, .instr, .dec, .aluCtrl, .shiftZero,
        .instrReg, .capture, .shiftLoad, .regWe, .busy, .done, .illegal
    );

    mainDecode mainDecode_inst (.instr(instrReg), .dec);

    aluDecode aluDecode_inst (
        .aluOp(dec.aluOp), .funct3(dec.funct3), .funct75(dec.funct75), .aluCtrl
    );

    regFile #(.regCount(regCount)) regFile_inst (
        .clk, .rstN, .rs1(dec.rs1), .rs2(dec.rs2), .rd(dec.rd),
        .wrEn(regWe), .wrData(result), .rs1Data, .rs2Data
    );

    shiftTimer shiftTimer_inst (
        .clk, .rstN, .load(shiftLoad), .amount(shamt), .step(shiftStep), .zero(shiftZero)
    );

    execAlu execAlu_inst (
        .clk, .rstN, .capture, .shiftStep, .aluCtrl,
        .srcA(rs1Data), .srcB, .result, .taken, .shamt
    );

endmodule

`default_nettype wire

// File: design/shiftTimer.sv
`timescale 1ns/1ps
`default_nettype none

module shiftTimer (
    input  logic             clk,
    input  logic             rstN,
    input  logic             load,    // Start a new shift
    input  rvExecPkg::shamtT amount,  // Positions to shift
    output logic             step,    // One position this cycle
    output logic             zero     // Nothing left to count
);

    rvExecPkg::shamtT count;

    assign step = (count != '0);
    assign zero = (count == '0);

    always_ff @(posedge clk) begin
        if (!rstN) begin
            count <= '0;
        end else if (load) begin
            count <= amount;
        end else if (step) begin
            count <= count - 1'b1;  // Stops at zero
        end
    end

    assert property (@(posedge clk) disable iff (!rstN) !load |=> count <= $past(count))
        else $error("Shift count rose without a load");

endmodule

`default_nettype wire

// File: tb.f
+incdir+tests
design/rvExecPkg.sv
design/mainDecode.sv
design/aluDecode.sv
design/regFile.sv
design/shiftTimer.sv
design/execAlu.sv
design/execControl.sv
design/rvExecUnit.sv
tests/rvExecUnitTb.sv

// File: tests/rvExecModel.svh
`ifndef rvExecModelSvh
`define rvExecModelSvh

// Expected outcome of one instruction
typedef struct packed {
    logic [31:0] result;
    logic [4:0]  rdAddr;
    logic        wrEn;
    logic        taken;
    logic        illegal;
    logic        checkResult;  // Only register-writing classes
    logic [5:0]  latency;      // Cycles from accept edge to done
} expectT;

logic [31:0] shadowRegs [32];  // Shadow register file

function automatic logic [31:0] readShadow(input logic [4:0] idx);
    return (idx == 5'd0) ? 32'h0 : shadowRegs[idx];  // x0 reads zero
endfunction

// Result by funct3, alt is bit 30 where it picks sub or sra
function automatic logic [31:0] aluModel(input logic [2:0] f3, input logic alt,
                                         input logic [31:0] a, input logic [31:0] b);
    logic signed [31:0] sa;
    sa = a;
    if (alt && f3 != 3'b000 && f3 != 3'b101) begin
        return a + b;  // Unlisted bit 30 pairs fall back to add
    end
    case (f3)
        3'b000:  return alt ? a - b : a + b;
        3'b001:  return a << b[4:0];
        3'b010:  return {31'b0, $signed(a) < $signed(b)};
        3'b011:  return {31'b0, a < b};
        3'b100:  return a ^ b;
        3'b101: begin
            if (alt) begin
                return sa >>> b[4:0];  // Sign fill
            end
            return a >> b[4:0];
        end
        3'b110:  return a | b;
        default: return a & b;
    endcase
endfunction

function automatic logic branchModel(input logic [2:0] f3, input logic [31:0] a,
                                     input logic [31:0] b);
    case (f3)
        3'b000:  return a == b;
        3'b001:  return a != b;
        3'b100:  return $signed(a) < $signed(b);
        3'b101:  return $signed(a) >= $signed(b);
        3'b110:  return a < b;
        3'b111:  return a >= b;
        default: return 1'b0;  // Reserved, never taken
    endcase
endfunction

function automatic expectT predict(input logic [31:0] word);
    expectT      e;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm;
    logic [2:0]  f3;
    logic        alt;
    logic        writes;
    e         = '0;
    writes    = 1'b0;
    f3        = word[14:12];
    a         = readShadow(word[19:15]);
    b         = readShadow(word[24:20]);
    imm       = {{20{word[31]}}, word[31:20]};
    e.rdAddr  = word[11:7];
    e.latency = 6'd3;
    case (word[6:0])
        7'b0110011: begin  // R-type
            e.result = aluModel(f3, word[30], a, b);
            writes   = 1'b1;
            if (f3 == 3'b101 || (f3 == 3'b001 && !word[30])) begin
                e.latency = 6'd3 + 6'(b[4:0]);  // One clock per position
            end
        end
        7'b0010011: begin  // I-type, bit 30 counts only for srai
            alt      = (f3 == 3'b101) && word[30];
            e.result = aluModel(f3, alt, a, imm);
            writes   = 1'b1;
            if (f3 == 3'b001 || f3 == 3'b101) begin
                e.latency = 6'd3 + 6'(imm[4:0]);
            end
        end
        7'b1100011: e.taken = branchModel(f3, a, b);  // Writes nothing
        7'b0110111: begin
            e.result = {word[31:12], 12'h0};
            writes   = 1'b1;
        end
        default: begin
            e.illegal = 1'b1;
            e.latency = 6'd2;  // Execution skipped
        end
    endcase
    e.checkResult = writes;
    e.wrEn        = writes && (word[11:7] != 5'd0);
    return e;
endfunction

function automatic void commit(input expectT e);
    if (e.wrEn) begin
        shadowRegs[e.rdAddr] = e.result;
    end
endfunction

`endif

// File: tests/rvExecUnitTb.sv
`timescale 1ns/1ps
`default_nettype none

module rvExecUnitTb;

    localparam int doneTimeout = 64;  // Longest legal latency is 34
    localparam int idleTimeout = 8;

    logic        clk = 1'b0;
    logic        rstN;
    logic        instrValid;
    logic [31:0] instr;
    logic        busy;
    logic        done;
    logic [4:0]  rdAddr;
    logic [31:0] result;
    logic        wrEn;
    logic        branchTaken;
    logic        illegal;

    `include "rvExecModel.svh"

    rvExecUnit #(.regCount(32)) rvExecUnit_inst (
        .clk, .rstN, .instrValid, .instr, .busy, .done,
        .rdAddr, .result, .wrEn, .branchTaken, .illegal
    );

    always #20 clk = ~clk;  // 40 ns period

    task automatic stopRun(input string why);
        $display("%s", why);
        $display("Checks failed");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic checkEq(input string what, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            stopRun($sformatf("Fail at %0d ns: %s is %h, expected %h", $time, what, got, exp));
        end
    endtask

    function automatic logic [4:0] randReg();
        return 5'($urandom);
    endfunction

    function automatic logic [31:0] encR(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] encI(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd);
        return {imm, rs1, f3, rd, 7'b0010011};
    endfunction

    function automatic logic [31:0] encB(input logic [2:0] f3, input logic [4:0] rs1,
                                         input logic [4:0] rs2);
        return {7'($urandom), rs2, rs1, f3, 5'($urandom), 7'b1100011};  // Offset is noise
    endfunction

    function automatic logic [31:0] encU(input logic [19:0] imm, input logic [4:0] rd);
        return {imm, rd, 7'b0110111};
    endfunction

    task automatic waitIdle(input string tag);
        int cycles;
        cycles = 0;
        while (busy !== 1'b0) begin
            if (cycles == idleTimeout) begin
                stopRun($sformatf("Timeout: unit stayed busy before %s", tag));
            end else begin
                @(posedge clk);
                #2;
                cycles++;
            end
        end
    endtask

    // Issue one word, wait for done and compare every result field
    task automatic runInstr(input logic [31:0] word, input string tag);
        expectT exp;
        int     cycles;
        string  what;
        waitIdle(tag);
        exp        = predict(word);
        what       = $sformatf("%s %h", tag, word);
        instr      = word;
        instrValid = 1'b1;
        @(posedge clk);  // Accept edge
        #2;
        cycles = 1;
        while (done !== 1'b1) begin
            checkEq({what, " busy"}, busy, 1'b1);
            if (cycles >= doneTimeout) begin
                stopRun($sformatf("Timeout: instruction %h (%s) never signalled done", word, tag));
            end else begin
                instrValid = 1'($urandom_range(1, 0));  // Stray strobe while busy
                instr      = $urandom;
                @(posedge clk);
                #2;
                cycles++;
            end
        end
        instrValid = 1'b0;
        checkEq({what, " latency"}, cycles, exp.latency);
        checkEq({what, " busy at done"}, busy, 1'b1);
        checkEq({what, " wrEn"}, wrEn, exp.wrEn);
        checkEq({what, " rdAddr"}, rdAddr, exp.rdAddr);
        checkEq({what, " illegal"}, illegal, exp.illegal);
        checkEq({what, " branchTaken"}, branchTaken, exp.taken);
        if (exp.checkResult) begin
            checkEq({what, " result"}, result, exp.result);
        end
        commit(exp);
        @(posedge clk);
        #2;
        checkEq({what, " done pulse width"}, done, 1'b0);
        checkEq({what, " busy after done"}, busy, 1'b0);
    endtask

    initial begin
        logic [2:0] iOps [6];
        logic [2:0] bOps [6];
        logic [2:0] f3;
        logic [4:0] rA;
        logic [4:0] rB;
        logic [4:0] rD;
        logic [4:0] amt;
        logic [6:0] badOp;
        logic       alt;
        iOps = '{3'b000, 3'b010, 3'b011, 3'b100, 3'b110, 3'b111};  // No shifts
        bOps = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
        void'($urandom(32'he478_b7c9));
        rstN       = 1'b0;
        instrValid = 1'b0;
        instr      = '0;
        foreach (shadowRegs[i]) begin
            shadowRegs[i] = '0;
        end
        repeat (4) @(posedge clk);
        #2;
        rstN = 1'b1;

        repeat (6) begin  // Quiet after reset
            @(posedge clk);
            #2;
            checkEq("idle busy", busy, 1'b0);
            checkEq("idle done", done, 1'b0);
            checkEq("idle wrEn", wrEn, 1'b0);
            checkEq("idle illegal", illegal, 1'b0);
        end
        repeat (4) begin
            runInstr(encR(7'h0, randReg(), randReg(), 3'b000, randReg()), "add after reset");
        end

        for (int r = 1; r < 32; r++) begin  // Fill every register
            runInstr(encU(20'($urandom), 5'(r)), "lui");
            runInstr(encI(12'($urandom), 5'(r), 3'b000, 5'(r)), "addi");
        end
        repeat (40) begin
            f3 = iOps[$urandom_range(5, 0)];
            runInstr(encI(12'($urandom), randReg(), f3, randReg()), "I-type");
        end

        repeat (60) begin  // Random funct7 with bit 30
            runInstr(encR(7'($urandom), randReg(), randReg(), 3'($urandom), randReg()), "R-type");
        end

        repeat (40) begin
            amt = 5'($urandom);
            alt = 1'($urandom);
            f3  = ($urandom_range(1, 0) != 0) ? 3'b001 : 3'b101;
            rA  = randReg();
            rB  = randReg();
            rD  = randReg();
            runInstr(encI({1'b0, alt && f3 == 3'b101, 5'b0, amt}, rA, f3, rD), "shift imm");
            runInstr(encR({1'b0, alt && f3 == 3'b101, 5'b0}, rB, rA, f3, rD), "shift reg");
        end
        runInstr(encI(12'h000, 5'd3, 3'b001, 5'd4), "slli by 0");
        runInstr(encI(12'h41f, 5'd3, 3'b101, 5'd5), "srai by 31");

        repeat (36) begin
            f3 = bOps[$urandom_range(5, 0)];
            rA = randReg();
            rB = randReg();
            case ($urandom_range(2, 0))
                0: rB = rA;  // Same register
                1: if (rB != 5'd0) runInstr(encI(12'h0, rA, 3'b000, rB), "copy");
                default: ;
            endcase
            runInstr(encB(f3, rA, rB), "branch");
        end

        runInstr(encI(12'h7ff, 5'd9, 3'b000, 5'd0), "addi to x0");
        runInstr(encU(20'hfffff, 5'd0), "lui to x0");
        runInstr(encR(7'h0, 5'd9, 5'd8, 3'b110, 5'd0), "or to x0");
        runInstr(encR(7'h0, 5'd0, 5'd0, 3'b000, 5'd7), "x0 read back");
        runInstr(encB(3'b000, 5'd0, 5'd0), "beq x0 x0");
        repeat (12) begin
            badOp = 7'($urandom);
            if (badOp inside {7'b0110011, 7'b0010011, 7'b1100011, 7'b0110111}) begin
                badOp = badOp ^ 7'b1000000;  // Lands on an unsupported opcode
            end
            runInstr({25'($urandom), badOp}, "unsupported");
        end
        runInstr(32'h0, "all-zero word");
        runInstr(encR(7'h0, 5'd2, 5'd1, 3'b000, 5'd6), "add after unsupported");

        $display("All checks passed");
        $finish;
    end

endmodule

`default_nettype wire
